//--- ndn_input.txt
# I type length prefix outcome (F forward, A aggregate, X drop, N ignore)
# D prefix outcome (A accept, R drop); B accepted_prefix prefix_sent_while_busy
I 1 10 A0B1000000000000 F
I 0 10 1111000000000000 N
I 1 10 A0B1000000000000 A
I 1 20 C0DE123400000000 F
I 1 08 5500000000000000 F
I 1 3F 0123456789ABCDEF F
# Table is full now
I 1 10 FFFF000000000000 X
I 1 3F 0123456789ABCDEF A
D A0B1FFFF12345678 A
D A0B1FFFF12345678 R
D 9999000000000000 R
B C0DE1234AAAAAAAA 55AA000000000000
# Entry left pending by the busy drop
D 55AB000000000000 A
# Length 0 matches any name and sits in the lowest slot
I 1 00 0000000000000000 F
D 0123456789ABCDEE A
D 0123456789ABCDEE A
D 0123456789ABCDEF R

//--- all.f
+incdir+.
ndn_pkg.sv
mcu_interest_rx.sv
pit_table.sv
mcu_data_tx.sv
ndn_mcu_port.sv
tb_clock_gen.sv
tb_ndn_mcu_port.sv

//--- Bender.yml
package:
  name: ndn_mcu_port

sources:
  - include_dirs:
      - .
    files:
      - ndn_pkg.sv
      - mcu_interest_rx.sv
      - pit_table.sv
      - mcu_data_tx.sv
      - ndn_mcu_port.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_ndn_mcu_port.sv

//--- tb_ndn_mcu_port.sv
// Reads ndn_input.txt from the project root; payload bytes come from $urandom with a fixed seed
`timescale 1ns/100ps
`default_nettype none

`include "ndn_macros.svh"

module tb_ndn_mcu_port;

    localparam STIM_FILE = "ndn_input.txt";
    localparam int SEED = 32'h7ee0;
    // Spare cycles for reset and idle gaps
    localparam int MARGIN = 200;
    localparam int PW = $bits(ndn_pkg::payload_t);
    localparam int RX_BITS = 2 + $bits(ndn_pkg::plen_t) + `NDN_PREFIX_BITS;
    localparam int TX_BITS = 2 + `NDN_PREFIX_BITS + PW;

    logic              clk;
    logic              rst;
    logic              mosi;
    logic              miso;
    logic              interest_valid;
    ndn_pkg::prefix_t  interest_prefix;
    ndn_pkg::plen_t    interest_length;
    logic              interest_drop;
    logic              data_start;
    ndn_pkg::prefix_t  data_prefix;
    logic              data_drop;
    logic              data_byte_valid;
    ndn_pkg::byte_t    data_byte;
    logic              tx_busy;

    int err_count   = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int cycle_count = 0;
    // Grows by each command's cost as the command is read
    int cycle_limit = MARGIN;

    tb_clock_gen i_clk (
        .clk (clk),
        .rst (rst)
    );

    ndn_mcu_port i_dut (
        .clk             (clk),
        .rst             (rst),
        .mosi            (mosi),
        .miso            (miso),
        .interest_valid  (interest_valid),
        .interest_prefix (interest_prefix),
        .interest_length (interest_length),
        .interest_drop   (interest_drop),
        .data_start      (data_start),
        .data_prefix     (data_prefix),
        .data_drop       (data_drop),
        .data_byte_valid (data_byte_valid),
        .data_byte       (data_byte),
        .tx_busy         (tx_busy)
    );

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [PW-1:0] exp, input logic [PW-1:0] act);
        $display("mismatch %s %s: expected %0h actual %0h", name, what, exp, act);
        err_count++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail", name);
        end
    endtask

    // Start bit, type, length and prefix, then watch four cycles for the table's answer
    task automatic run_interest(input string name, input logic itype, input ndn_pkg::plen_t ilen,
                                input ndn_pkg::prefix_t ipfx, input logic [7:0] outc);
        logic [RX_BITS-1:0] frame;
        int                 errs_before;
        int                 valid_at;
        int                 drop_at;
        int                 i;
        ndn_pkg::prefix_t   got_prefix;
        ndn_pkg::plen_t     got_len;
        errs_before = err_count;
        frame      = {1'b0, itype, ilen, ipfx};
        valid_at   = 0;
        drop_at    = 0;
        got_prefix = '0;
        got_len    = '0;
        for (i = RX_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            mosi <= frame[i];
        end
        @(posedge clk);
        mosi <= 1'b1;
        // Cycle 2 counts from the edge that drove the last prefix bit
        for (i = 1; i <= 4; i++) begin
            @(negedge clk);
            if (interest_valid && valid_at == 0) begin
                valid_at   = i;
                got_prefix = interest_prefix;
                got_len    = interest_length;
            end
            if (interest_drop && drop_at == 0) begin
                drop_at = i;
            end
        end
        if (outc == "F") begin
            if (valid_at == 0) begin
                $display("test %s: interest_valid never fired", name);
                err_count++;
            end else if (valid_at != 2) begin
                report_mismatch(name, "interest_valid cycle", 2, valid_at);
            end
            if (valid_at != 0 && got_prefix != ipfx) begin
                report_mismatch(name, "interest_prefix", ipfx, got_prefix);
            end
            if (valid_at != 0 && got_len != ilen) begin
                report_mismatch(name, "interest_length", ilen, got_len);
            end
            if (drop_at != 0) begin
                report_mismatch(name, "interest_drop cycle", 0, drop_at);
            end
        end else if (outc == "X") begin
            if (drop_at != 2) begin
                report_mismatch(name, "interest_drop cycle", 2, drop_at);
            end
            if (valid_at != 0) begin
                report_mismatch(name, "interest_valid cycle", 0, valid_at);
            end
        end else if (outc == "A" || outc == "N") begin
            if (valid_at != 0 || drop_at != 0) begin
                $display("test %s: aggregated or ignored frame reached the network side", name);
                err_count++;
            end
        end else begin
            $display("test %s: unknown interest outcome code %c", name, outc);
            err_count++;
        end
        close_test(name, errs_before);
    endtask

    // One data_start strobe, drop sampled one cycle later
    task automatic strobe_data(input ndn_pkg::prefix_t pfx, output logic drop_seen);
        @(posedge clk);
        data_start  <= 1'b1;
        data_prefix <= pfx;
        @(posedge clk);
        data_start  <= 1'b0;
        @(negedge clk);
        drop_seen = data_drop;
    endtask

    task automatic wait_busy(output logic ok);
        int n;
        n = 0;
        while (!tx_busy && n < 4) begin
            @(negedge clk);
            n++;
        end
        ok = tx_busy;
    endtask

    // Random bytes with 0 to 2 idle cycles between strobes, first byte ends up on top
    task automatic send_payload(output ndn_pkg::payload_t sent);
        ndn_pkg::byte_t b;
        int             k;
        int             gap;
        sent = '0;
        for (k = 0; k < `NDN_PAYLOAD_BYTES; k++) begin
            b    = ndn_pkg::byte_t'($urandom);
            sent = {sent[PW-$bits(ndn_pkg::byte_t)-1:0], b};
            @(posedge clk);
            data_byte_valid <= 1'b1;
            data_byte       <= b;
            if (k != `NDN_PAYLOAD_BYTES - 1) begin
                gap = $urandom % 3;
                repeat (gap) begin
                    @(posedge clk);
                    data_byte_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        data_byte_valid <= 1'b0;
    endtask

    // Deserializer on miso; delay 0 means the start bit came right after the last byte
    task automatic capture_frame(output logic found, output int delay,
                                 output logic [TX_BITS-1:0] bits,
                                 output logic idle_bit, output logic busy_after);
        int i;
        bits       = '0;
        delay      = 0;
        idle_bit   = 1'b0;
        busy_after = 1'b1;
        @(negedge clk);
        while (miso && delay < 8) begin
            @(negedge clk);
            delay++;
        end
        found = !miso;
        if (found) begin
            bits = {bits[TX_BITS-2:0], miso};
            for (i = 1; i < TX_BITS; i++) begin
                @(negedge clk);
                bits = {bits[TX_BITS-2:0], miso};
            end
            @(negedge clk);
            idle_bit   = miso;
            busy_after = tx_busy;
        end
    endtask

    task automatic load_and_check(input string name, input ndn_pkg::prefix_t pfx);
        ndn_pkg::payload_t    sent;
        logic [TX_BITS-1:0]   bits;
        int                   delay;
        logic                 found;
        logic                 idle_bit;
        logic                 busy_after;
        send_payload(sent);
        capture_frame(found, delay, bits, idle_bit, busy_after);
        if (!found) begin
            $display("test %s: no frame appeared on miso after the last byte", name);
            err_count++;
        end else begin
            if (delay != 0) begin
                report_mismatch(name, "frame start delay", 0, delay);
            end
            if (bits[TX_BITS-2] != 1'b0) begin
                report_mismatch(name, "type bit", 0, bits[TX_BITS-2]);
            end
            if (bits[TX_BITS-3 -: `NDN_PREFIX_BITS] != pfx) begin
                report_mismatch(name, "frame prefix", pfx, bits[TX_BITS-3 -: `NDN_PREFIX_BITS]);
            end
            if (bits[PW-1:0] != sent) begin
                report_mismatch(name, "frame payload", sent, bits[PW-1:0]);
            end
            if (!idle_bit) begin
                report_mismatch(name, "miso after frame", 1, idle_bit);
            end
            if (busy_after) begin
                report_mismatch(name, "tx_busy after frame", 0, busy_after);
            end
        end
    endtask

    task automatic run_data(input string name, input ndn_pkg::prefix_t pfx,
                            input logic [7:0] outc);
        int   errs_before;
        int   i;
        logic drop_seen;
        logic ok;
        logic frame_seen;
        errs_before = err_count;
        strobe_data(pfx, drop_seen);
        if (outc == "A") begin
            if (drop_seen) begin
                report_mismatch(name, "data_drop", 0, drop_seen);
            end
            wait_busy(ok);
            if (!ok) begin
                $display("test %s: tx_busy never rose after the data was accepted", name);
                err_count++;
            end else begin
                load_and_check(name, pfx);
            end
        end else if (outc == "R") begin
            if (!drop_seen) begin
                report_mismatch(name, "data_drop", 1, drop_seen);
            end
            // A dropped packet must leave the serializer idle
            frame_seen = 1'b0;
            for (i = 0; i < 8; i++) begin
                @(negedge clk);
                if (tx_busy || !miso) begin
                    frame_seen = 1'b1;
                end
            end
            if (frame_seen) begin
                $display("test %s: transmitter started on dropped data", name);
                err_count++;
            end
        end else begin
            $display("test %s: unknown data outcome code %c", name, outc);
            err_count++;
        end
        close_test(name, errs_before);
    endtask

    // First packet is accepted, second arrives while busy and is dropped
    task automatic run_busy(input string name, input ndn_pkg::prefix_t first_pfx,
                            input ndn_pkg::prefix_t busy_pfx);
        int   errs_before;
        logic drop_seen;
        logic ok;
        errs_before = err_count;
        strobe_data(first_pfx, drop_seen);
        if (drop_seen) begin
            report_mismatch(name, "data_drop on first packet", 0, drop_seen);
        end
        wait_busy(ok);
        if (!ok) begin
            $display("test %s: tx_busy never rose after the first packet", name);
            err_count++;
        end else begin
            strobe_data(busy_pfx, drop_seen);
            if (!drop_seen) begin
                report_mismatch(name, "data_drop while busy", 1, drop_seen);
            end
            load_and_check(name, first_pfx);
        end
        close_test(name, errs_before);
    endtask

    initial begin : main
        int                  fd;
        int                  code;
        int                  test_num;
        int                  errs_before;
        int                  i;
        logic                more;
        logic [7:0]          cmd;
        logic [7:0]          outc;
        logic                itype;
        ndn_pkg::plen_t      ilen;
        ndn_pkg::prefix_t    pfx_a;
        ndn_pkg::prefix_t    pfx_b;
        logic [8*160-1:0]    line_buf;
        mosi            <= 1'b1;
        data_start      <= 1'b0;
        data_prefix     <= '0;
        data_byte_valid <= 1'b0;
        data_byte       <= '0;
        void'($urandom(SEED));
        test_num = 0;
        wait (rst === 1'b0);
        // Idle state straight after reset
        errs_before = err_count;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            if (miso !== 1'b1) begin
                report_mismatch("reset", "miso", 1, miso);
            end
            if (interest_valid !== 1'b0 || interest_drop !== 1'b0) begin
                $display("test reset: interest strobe fired with no frame sent");
                err_count++;
            end
            if (data_drop !== 1'b0 || tx_busy !== 1'b0) begin
                $display("test reset: data side not idle after reset");
                err_count++;
            end
        end
        close_test("reset", errs_before);
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            err_count++;
        end else begin
            more = 1'b1;
            while (more) begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1) begin
                    more = 1'b0;
                end else if (cmd == "#") begin
                    code = $fgets(line_buf, fd);
                end else if (cmd == "I") begin
                    code = $fscanf(fd, " %h %h %h %c", itype, ilen, pfx_a, outc);
                    cycle_limit += 96;
                    test_num++;
                    if (code != 4) begin
                        $display("malformed interest line in %s", STIM_FILE);
                        err_count++;
                        more = 1'b0;
                    end else begin
                        run_interest($sformatf("interest_%0d", test_num), itype, ilen,
                                     pfx_a, outc);
                    end
                end else if (cmd == "D") begin
                    code = $fscanf(fd, " %h %c", pfx_a, outc);
                    cycle_limit += 520;
                    test_num++;
                    if (code != 2) begin
                        $display("malformed data line in %s", STIM_FILE);
                        err_count++;
                        more = 1'b0;
                    end else begin
                        run_data($sformatf("data_%0d", test_num), pfx_a, outc);
                    end
                end else if (cmd == "B") begin
                    code = $fscanf(fd, " %h %h", pfx_a, pfx_b);
                    cycle_limit += 560;
                    test_num++;
                    if (code != 2) begin
                        $display("malformed busy line in %s", STIM_FILE);
                        err_count++;
                        more = 1'b0;
                    end else begin
                        run_busy($sformatf("busy_%0d", test_num), pfx_a, pfx_b);
                    end
                end else begin
                    $display("unknown command %c in %s", cmd, STIM_FILE);
                    err_count++;
                    more = 1'b0;
                end
            end
            $fclose(fd);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 pass_count + fail_count, pass_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Free-running 100 ns clock; reset is held high over the first five rising edges
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released on a rising edge, like any other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- ndn_mcu_port.sv
// One MCU on a clk-sampled serial pair; the network side sees only strobes and levels, no handshake
`timescale 1ns/100ps
`default_nettype none

module ndn_mcu_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              mosi,
    output logic              miso,
    output logic              interest_valid,
    output ndn_pkg::prefix_t  interest_prefix,
    output ndn_pkg::plen_t    interest_length,
    output logic              interest_drop,
    input  logic              data_start,
    input  ndn_pkg::prefix_t  data_prefix,
    output logic              data_drop,
    input  logic              data_byte_valid,
    input  ndn_pkg::byte_t    data_byte,
    output logic              tx_busy
);

    // Deframed interest toward the table
    logic             rx_interest;
    ndn_pkg::prefix_t rx_prefix;
    ndn_pkg::plen_t   rx_length;

    // Matched data toward the serializer
    logic             tx_accept;
    ndn_pkg::prefix_t tx_prefix;

    mcu_interest_rx i_rx (
        .clk         (clk),
        .rst         (rst),
        .mosi        (mosi),
        .rx_interest (rx_interest),
        .rx_prefix   (rx_prefix),
        .rx_length   (rx_length)
    );

    pit_table i_pit (
        .clk             (clk),
        .rst             (rst),
        .rx_interest     (rx_interest),
        .rx_prefix       (rx_prefix),
        .rx_length       (rx_length),
        .data_start      (data_start),
        .data_prefix     (data_prefix),
        .tx_busy         (tx_busy),
        .interest_valid  (interest_valid),
        .interest_prefix (interest_prefix),
        .interest_length (interest_length),
        .interest_drop   (interest_drop),
        .tx_accept       (tx_accept),
        .tx_prefix       (tx_prefix),
        .data_drop       (data_drop)
    );

    mcu_data_tx i_tx (
        .clk             (clk),
        .rst             (rst),
        .tx_accept       (tx_accept),
        .tx_prefix       (tx_prefix),
        .data_byte_valid (data_byte_valid),
        .data_byte       (data_byte),
        .tx_busy         (tx_busy),
        .miso            (miso)
    );

endmodule

`default_nettype wire

//--- mcu_data_tx.sv
// Exactly NDN_PAYLOAD_BYTES byte strobes are expected after each accept; miso is a decode of the FSM
`timescale 1ns/100ps
`default_nettype none

`include "ndn_macros.svh"

module mcu_data_tx (
    input  logic              clk,
    input  logic              rst,
    input  logic              tx_accept,
    input  ndn_pkg::prefix_t  tx_prefix,
    input  logic              data_byte_valid,
    input  ndn_pkg::byte_t    data_byte,
    output logic              tx_busy,
    output logic              miso
);

    localparam int PAYLOAD_W = $bits(ndn_pkg::payload_t);
    localparam int BYTE_W    = $bits(ndn_pkg::byte_t);
    // Counts bytes while loading, then prefix and payload bits
    localparam int CNT_W     = $clog2(PAYLOAD_W);

    ndn_pkg::tx_state_e state;
    logic [CNT_W-1:0]   cnt;
    ndn_pkg::prefix_t   prefix_sr;
    ndn_pkg::payload_t  payload_sr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ndn_pkg::TX_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ndn_pkg::TX_IDLE: begin
                    if (tx_accept) begin
                        cnt   <= '0;
                        state <= ndn_pkg::TX_LOAD;
                    end
                end
                ndn_pkg::TX_LOAD: begin
                    if (data_byte_valid) begin
                        if (cnt == CNT_W'(`NDN_PAYLOAD_BYTES - 1)) begin
                            cnt   <= '0;
                            state <= ndn_pkg::TX_START;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                ndn_pkg::TX_START: begin
                    state <= ndn_pkg::TX_TYPE;
                end
                ndn_pkg::TX_TYPE: begin
                    cnt   <= '0;
                    state <= ndn_pkg::TX_PREFIX;
                end
                ndn_pkg::TX_PREFIX: begin
                    if (cnt == CNT_W'(`NDN_PREFIX_BITS - 1)) begin
                        cnt   <= '0;
                        state <= ndn_pkg::TX_PAYLOAD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ndn_pkg::TX_PAYLOAD: begin
                    if (cnt == CNT_W'(PAYLOAD_W - 1)) begin
                        state <= ndn_pkg::TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ndn_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Same registers hold the packet while loading and shift it out later
    always_ff @(posedge clk) begin
        if (state == ndn_pkg::TX_IDLE && tx_accept) begin
            prefix_sr <= tx_prefix;
        end
        if (state == ndn_pkg::TX_LOAD && data_byte_valid) begin
            payload_sr <= {payload_sr[PAYLOAD_W-BYTE_W-1:0], data_byte};
        end
        if (state == ndn_pkg::TX_PREFIX) begin
            prefix_sr <= prefix_sr << 1;
        end
        if (state == ndn_pkg::TX_PAYLOAD) begin
            payload_sr <= payload_sr << 1;
        end
    end

    // Start bit and type bit are both low for a data frame
    always_comb begin
        case (state)
            ndn_pkg::TX_START:   miso = 1'b0;
            ndn_pkg::TX_TYPE:    miso = 1'b0;
            ndn_pkg::TX_PREFIX:  miso = prefix_sr[`NDN_PREFIX_BITS-1];
            ndn_pkg::TX_PAYLOAD: miso = payload_sr[PAYLOAD_W-1];
            default:             miso = 1'b1;
        endcase
    end

    // High from the cycle after accept through the last payload bit
    assign tx_busy = (state != ndn_pkg::TX_IDLE);

endmodule

`default_nettype wire

//--- pit_table.sv
// Single-cycle lookup over all entries; an interest aggregated onto an entry consumed that cycle is lost
`timescale 1ns/100ps
`default_nettype none

`include "ndn_macros.svh"

module pit_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_interest,
    input  ndn_pkg::prefix_t  rx_prefix,
    input  ndn_pkg::plen_t    rx_length,
    input  logic              data_start,
    input  ndn_pkg::prefix_t  data_prefix,
    input  logic              tx_busy,
    output logic              interest_valid,
    output ndn_pkg::prefix_t  interest_prefix,
    output ndn_pkg::plen_t    interest_length,
    output logic              interest_drop,
    output logic              tx_accept,
    output ndn_pkg::prefix_t  tx_prefix,
    output logic              data_drop
);

    logic [`NDN_PIT_DEPTH-1:0] ent_valid;
    ndn_pkg::prefix_t          ent_prefix [`NDN_PIT_DEPTH];
    ndn_pkg::plen_t            ent_length [`NDN_PIT_DEPTH];
    // Top ent_length bits set, all clear for a zero length
    ndn_pkg::prefix_t          ent_mask   [`NDN_PIT_DEPTH];

    logic              agg_hit;
    logic              free_found;
    ndn_pkg::pit_idx_t free_idx;
    logic              match_found;
    ndn_pkg::pit_idx_t match_idx;
    logic              store_new;
    logic              accept_ok;

    always_comb begin
        for (int i = 0; i < `NDN_PIT_DEPTH; i++) begin
            ent_mask[i] = ~({`NDN_PREFIX_BITS{1'b1}} >> ent_length[i]);
        end
    end

    // Aggregation check, lowest free slot and lowest masked match
    always_comb begin
        agg_hit     = 1'b0;
        free_found  = 1'b0;
        free_idx    = '0;
        match_found = 1'b0;
        match_idx   = '0;
        for (int i = 0; i < `NDN_PIT_DEPTH; i++) begin
            if (ent_valid[i] && ent_prefix[i] == rx_prefix && ent_length[i] == rx_length) begin
                agg_hit = 1'b1;
            end
            if (!free_found && !ent_valid[i]) begin
                free_found = 1'b1;
                free_idx   = ndn_pkg::pit_idx_t'(i);
            end
            if (!match_found && ent_valid[i] &&
                ((ent_prefix[i] ^ data_prefix) & ent_mask[i]) == '0) begin
                match_found = 1'b1;
                match_idx   = ndn_pkg::pit_idx_t'(i);
            end
        end
    end

    assign store_new = rx_interest && !agg_hit && free_found;
    // tx_accept also blocks since tx_busy only rises a cycle later
    assign accept_ok = match_found && !tx_busy && !tx_accept;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid      <= '0;
            interest_valid <= 1'b0;
            interest_drop  <= 1'b0;
            tx_accept      <= 1'b0;
            data_drop      <= 1'b0;
        end else begin
            interest_valid <= store_new;
            interest_drop  <= rx_interest && !agg_hit && !free_found;
            tx_accept      <= data_start && accept_ok;
            data_drop      <= data_start && !accept_ok;
            // Consumed and new slots never coincide, one is valid and one free
            if (data_start && accept_ok) begin
                ent_valid[match_idx] <= 1'b0;
            end
            if (store_new) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_new) begin
            ent_prefix[free_idx] <= rx_prefix;
            ent_length[free_idx] <= rx_length;
        end
        if (rx_interest) begin
            interest_prefix <= rx_prefix;
            interest_length <= rx_length;
        end
        // Data prefix goes out in the MCU frame
        if (data_start) begin
            tx_prefix <= data_prefix;
        end
    end

endmodule

`default_nettype wire

//--- mcu_interest_rx.sv
// mosi is sampled once per clk with no sync or oversampling; data-typed frames are silently dropped
`timescale 1ns/100ps
`default_nettype none

`include "ndn_macros.svh"

module mcu_interest_rx (
    input  logic              clk,
    input  logic              rst,
    input  logic              mosi,
    output logic              rx_interest,
    output ndn_pkg::prefix_t  rx_prefix,
    output ndn_pkg::plen_t    rx_length
);

    // Counter wide enough for the prefix field, reused for the length field
    localparam int CNT_W = $bits(ndn_pkg::plen_t);

    ndn_pkg::rx_state_e state;
    logic [CNT_W-1:0]   bit_cnt;
    // Type bit of the frame in flight, 1 for interest
    logic               is_interest;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ndn_pkg::RX_IDLE;
            bit_cnt     <= '0;
            is_interest <= 1'b0;
        end else begin
            case (state)
                // DONE also watches for the next start bit
                ndn_pkg::RX_IDLE, ndn_pkg::RX_DONE: begin
                    if (!mosi) begin
                        state <= ndn_pkg::RX_TYPE;
                    end else begin
                        state <= ndn_pkg::RX_IDLE;
                    end
                end
                ndn_pkg::RX_TYPE: begin
                    is_interest <= mosi;
                    bit_cnt     <= '0;
                    state       <= ndn_pkg::RX_LENGTH;
                end
                ndn_pkg::RX_LENGTH: begin
                    if (bit_cnt == CNT_W'($bits(ndn_pkg::plen_t) - 1)) begin
                        bit_cnt <= '0;
                        state   <= ndn_pkg::RX_PREFIX;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ndn_pkg::RX_PREFIX: begin
                    if (bit_cnt == CNT_W'(`NDN_PREFIX_BITS - 1)) begin
                        state <= ndn_pkg::RX_DONE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ndn_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Field shift registers, MSB arrives first
    always_ff @(posedge clk) begin
        if (state == ndn_pkg::RX_LENGTH) begin
            rx_length <= {rx_length[$bits(ndn_pkg::plen_t)-2:0], mosi};
        end
        if (state == ndn_pkg::RX_PREFIX) begin
            rx_prefix <= {rx_prefix[`NDN_PREFIX_BITS-2:0], mosi};
        end
    end

    // One cycle after the last prefix bit, fields held stable meanwhile
    assign rx_interest = (state == ndn_pkg::RX_DONE) && is_interest;

endmodule

`default_nettype wire

//--- ndn_pkg.sv
// Shared vector types and FSM encodings; all widths derive from the defines in ndn_macros.svh
`default_nettype none

`include "ndn_macros.svh"

package ndn_pkg;

    // Full name prefix as carried in both frame types
    typedef logic [`NDN_PREFIX_BITS-1:0] prefix_t;

    // Significant prefix bits, 0 matches every name
    typedef logic [$clog2(`NDN_PREFIX_BITS)-1:0] plen_t;

    // One payload byte from the network side
    typedef logic [`NDN_BYTE_BITS-1:0] byte_t;

    // Whole payload, first byte in the top bits
    typedef logic [`NDN_BYTE_BITS*`NDN_PAYLOAD_BYTES-1:0] payload_t;

    // Table entry index
    typedef logic [$clog2(`NDN_PIT_DEPTH)-1:0] pit_idx_t;

    // Interest deframer states
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_TYPE,
        RX_LENGTH,
        RX_PREFIX,
        RX_DONE
    } rx_state_e;

    // Data serializer states
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_LOAD,
        TX_START,
        TX_TYPE,
        TX_PREFIX,
        TX_PAYLOAD
    } tx_state_e;

endpackage

`default_nettype wire

//--- ndn_macros.svh
// Sizing defines for the NDN MCU port; prefix width must be a power of two and depth at least 2
`ifndef NDN_MACROS_SVH
`define NDN_MACROS_SVH

// Number of pending interest table entries
`define NDN_PIT_DEPTH 4

// Name prefix width in bits, carried MSB first on both serial lines
`define NDN_PREFIX_BITS 64

// Payload bytes per data packet from the network side
`define NDN_PAYLOAD_BYTES 32

// Byte width of the network-side payload bus
`define NDN_BYTE_BITS 8

`endif
